//--- files.f
src/sram_ctrl_pkg.sv
src/axil_sram_bridge.sv
src/sram_io_driver.sv
src/axil_sram_top.sv
tests/tb_clock.sv
tests/async_sram_model.sv
tests/axil_sram_checker.sv
tests/axil_sram_props.sv
tests/tb_axil_sram.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_axil_sram -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  exit 0
else
  exit 1
fi

//--- src/axil_sram_bridge.sv
`timescale 1ns/1ps

module axil_sram_bridge
  import sram_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_rst,

  input  logic [AXIL_ADDR_W-1:0] i_awaddr,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  logic [AXIL_DATA_W-1:0] i_wdata,
  input  logic [AXIL_STRB_W-1:0] i_wstrb,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  output logic [1:0]             o_bresp,
  output logic                   o_bvalid,
  input  logic                   i_bready,

  input  logic [AXIL_ADDR_W-1:0] i_araddr,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  output logic [AXIL_DATA_W-1:0] o_rdata,
  output logic [1:0]             o_rresp,
  output logic                   o_rvalid,
  input  logic                   i_rready,

  output logic                   o_cmd_valid,
  input  logic                   i_cmd_ready,
  output logic [SRAM_ADDR_W-1:0] o_cmd_addr,
  output logic                   o_cmd_wr_en,
  output logic [AXIL_DATA_W-1:0] o_cmd_wr_data,
  output logic [AXIL_STRB_W-1:0] o_cmd_wr_strb,

  input  logic                   i_rd_valid,
  output logic                   o_rd_ready,
  input  logic [AXIL_DATA_W-1:0] i_rd_data
);

  bridge_state_e state;

  logic                   aw_done;
  logic                   w_done;
  logic                   last_wr;
  logic                   write_pend;
  logic                   pick_rd;
  logic [SRAM_ADDR_W-1:0] aw_word;
  logic [SRAM_ADDR_W-1:0] cmd_addr_q;
  logic [AXIL_DATA_W-1:0] w_data_q;
  logic [AXIL_STRB_W-1:0] w_strb_q;
  logic [AXIL_DATA_W-1:0] rdata_q;

  // Beats are taken independently, each only once per write
  assign o_awready = (state == BR_IDLE) && !aw_done && i_awvalid;
  assign o_wready  = (state == BR_IDLE) && !w_done && i_wvalid;

  assign write_pend = aw_done && w_done;

  // Read wins unless a write is ready and the last one served was a read
  assign pick_rd   = i_arvalid && (!write_pend || last_wr);
  assign o_arready = (state == BR_IDLE) && pick_rd;

  assign o_cmd_valid   = (state == BR_CMD_WR) || (state == BR_CMD_RD);
  assign o_cmd_wr_en   = (state == BR_CMD_WR);
  assign o_cmd_addr    = cmd_addr_q;
  assign o_cmd_wr_data = w_data_q;
  assign o_cmd_wr_strb = w_strb_q;

  assign o_rd_ready = (state == BR_WAIT_RD);

  assign o_bvalid = (state == BR_B_RESP);
  assign o_bresp  = RESP_OKAY;
  assign o_rvalid = (state == BR_R_RESP);
  assign o_rresp  = RESP_OKAY;
  assign o_rdata  = rdata_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state   <= BR_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
      last_wr <= 1'b0;
    end else begin
      if (o_awready) begin
        aw_done <= 1'b1;
      end
      if (o_wready) begin
        w_done <= 1'b1;
      end

      case (state)
        BR_IDLE: begin
          if (pick_rd) begin
            state   <= BR_CMD_RD;
            last_wr <= 1'b0;
          end else if (write_pend) begin
            state   <= BR_CMD_WR;
            last_wr <= 1'b1;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        BR_CMD_WR: begin
          if (i_cmd_ready) begin
            state <= BR_B_RESP;
          end
        end
        BR_CMD_RD: begin
          if (i_cmd_ready) begin
            state <= BR_WAIT_RD;
          end
        end
        BR_WAIT_RD: begin
          if (i_rd_valid) begin
            state <= BR_R_RESP;
          end
        end
        BR_B_RESP: begin
          if (i_bready) begin
            state <= BR_IDLE;
          end
        end
        BR_R_RESP: begin
          if (i_rready) begin
            state <= BR_IDLE;
          end
        end
        default: state <= BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    // Byte offset bit dropped, word address only
    if (o_awready) begin
      aw_word <= i_awaddr[AXIL_ADDR_W-1 -: SRAM_ADDR_W];
    end
    if (o_wready) begin
      w_data_q <= i_wdata;
      w_strb_q <= i_wstrb;
    end
    if (state == BR_IDLE) begin
      if (pick_rd) begin
        cmd_addr_q <= i_araddr[AXIL_ADDR_W-1 -: SRAM_ADDR_W];
      end else if (write_pend) begin
        cmd_addr_q <= aw_word;
      end
    end
    if (o_rd_ready && i_rd_valid) begin
      rdata_q <= i_rd_data;
    end
  end

endmodule

//--- src/axil_sram_top.sv
`timescale 1ns/1ps

module axil_sram_top
  import sram_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_rst,

  input  logic [AXIL_ADDR_W-1:0] i_awaddr,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  logic [AXIL_DATA_W-1:0] i_wdata,
  input  logic [AXIL_STRB_W-1:0] i_wstrb,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  output logic [1:0]             o_bresp,
  output logic                   o_bvalid,
  input  logic                   i_bready,

  input  logic [AXIL_ADDR_W-1:0] i_araddr,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  output logic [AXIL_DATA_W-1:0] o_rdata,
  output logic [1:0]             o_rresp,
  output logic                   o_rvalid,
  input  logic                   i_rready,

  output logic [SRAM_ADDR_W-1:0] o_sram_addr,
  inout  wire  [AXIL_DATA_W-1:0] io_sram_data,
  output logic                   o_sram_we_n,
  output logic                   o_sram_oe_n,
  output logic                   o_sram_ce_n
);

  // Command and read response between bridge and pin driver
  logic                   cmd_valid;
  logic                   cmd_ready;
  logic [SRAM_ADDR_W-1:0] cmd_addr;
  logic                   cmd_wr_en;
  logic [AXIL_DATA_W-1:0] cmd_wr_data;
  logic [AXIL_STRB_W-1:0] cmd_wr_strb;
  logic                   rd_valid;
  logic                   rd_ready;
  logic [AXIL_DATA_W-1:0] rd_data;

  axil_sram_bridge u_bridge (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_awaddr      (i_awaddr),
    .i_awvalid     (i_awvalid),
    .o_awready     (o_awready),
    .i_wdata       (i_wdata),
    .i_wstrb       (i_wstrb),
    .i_wvalid      (i_wvalid),
    .o_wready      (o_wready),
    .o_bresp       (o_bresp),
    .o_bvalid      (o_bvalid),
    .i_bready      (i_bready),
    .i_araddr      (i_araddr),
    .i_arvalid     (i_arvalid),
    .o_arready     (o_arready),
    .o_rdata       (o_rdata),
    .o_rresp       (o_rresp),
    .o_rvalid      (o_rvalid),
    .i_rready      (i_rready),
    .o_cmd_valid   (cmd_valid),
    .i_cmd_ready   (cmd_ready),
    .o_cmd_addr    (cmd_addr),
    .o_cmd_wr_en   (cmd_wr_en),
    .o_cmd_wr_data (cmd_wr_data),
    .o_cmd_wr_strb (cmd_wr_strb),
    .i_rd_valid    (rd_valid),
    .o_rd_ready    (rd_ready),
    .i_rd_data     (rd_data)
  );

  sram_io_driver u_io (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_cmd_valid   (cmd_valid),
    .o_cmd_ready   (cmd_ready),
    .i_cmd_addr    (cmd_addr),
    .i_cmd_wr_en   (cmd_wr_en),
    .i_cmd_wr_data (cmd_wr_data),
    .i_cmd_wr_strb (cmd_wr_strb),
    .o_rd_valid    (rd_valid),
    .i_rd_ready    (rd_ready),
    .o_rd_data     (rd_data),
    .o_sram_addr   (o_sram_addr),
    .io_sram_data  (io_sram_data),
    .o_sram_we_n   (o_sram_we_n),
    .o_sram_oe_n   (o_sram_oe_n),
    .o_sram_ce_n   (o_sram_ce_n)
  );

endmodule

//--- src/sram_ctrl_pkg.sv
package sram_ctrl_pkg;

  // AXI-Lite side
  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 16;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  // SRAM chip side, one word per 16-bit beat
  localparam int SRAM_ADDR_W = 7;
  localparam int SRAM_DEPTH  = 128;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic [2:0] {
    BR_IDLE,
    BR_CMD_WR,
    BR_CMD_RD,
    BR_WAIT_RD,
    BR_B_RESP,
    BR_R_RESP
  } bridge_state_e;

  typedef enum logic [2:0] {
    IO_IDLE,
    IO_RD_SETUP,
    IO_RD_SAMPLE,
    IO_WR_PULSE,
    IO_WR_RECOVER,
    IO_RD_RESP
  } io_state_e;

endpackage

//--- src/sram_io_driver.sv
`timescale 1ns/1ps

module sram_io_driver
  import sram_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_rst,

  input  logic                   i_cmd_valid,
  output logic                   o_cmd_ready,
  input  logic [SRAM_ADDR_W-1:0] i_cmd_addr,
  input  logic                   i_cmd_wr_en,
  input  logic [AXIL_DATA_W-1:0] i_cmd_wr_data,
  input  logic [AXIL_STRB_W-1:0] i_cmd_wr_strb,

  output logic                   o_rd_valid,
  input  logic                   i_rd_ready,
  output logic [AXIL_DATA_W-1:0] o_rd_data,

  output logic [SRAM_ADDR_W-1:0] o_sram_addr,
  inout  wire  [AXIL_DATA_W-1:0] io_sram_data,
  output logic                   o_sram_we_n,
  output logic                   o_sram_oe_n,
  output logic                   o_sram_ce_n
);

  io_state_e state;

  logic                   data_oe;
  logic                   wr_en_q;
  logic [AXIL_STRB_W-1:0] strb_q;
  logic [AXIL_DATA_W-1:0] wr_data_q;
  logic [AXIL_DATA_W-1:0] rd_data_q;
  logic [AXIL_DATA_W-1:0] merged;
  logic                   cmd_skip;
  logic                   cmd_full;

  assign o_cmd_ready = (state == IO_IDLE);
  assign o_rd_valid  = (state == IO_RD_RESP);
  assign o_rd_data   = rd_data_q;

  assign io_sram_data = data_oe ? wr_data_q : {AXIL_DATA_W{1'bz}};

  // Nothing to do for an empty strobe; full strobe needs no read first
  assign cmd_skip = i_cmd_wr_en && (i_cmd_wr_strb == '0);
  assign cmd_full = i_cmd_wr_en && (&i_cmd_wr_strb);

  // Old bytes from the chip where the strobe is clear
  always_comb begin
    for (int i = 0; i < AXIL_STRB_W; i++) begin
      merged[i*8 +: 8] = strb_q[i] ? wr_data_q[i*8 +: 8] : io_sram_data[i*8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state       <= IO_IDLE;
      o_sram_we_n <= 1'b1;
      o_sram_oe_n <= 1'b1;
      o_sram_ce_n <= 1'b1;
      data_oe     <= 1'b0;
    end else begin
      case (state)
        IO_IDLE: begin
          if (i_cmd_valid && !cmd_skip) begin
            o_sram_ce_n <= 1'b0;
            if (cmd_full) begin
              state       <= IO_WR_PULSE;
              o_sram_we_n <= 1'b0;
              data_oe     <= 1'b1;
            end else begin
              state       <= IO_RD_SETUP;
              o_sram_oe_n <= 1'b0;
            end
          end
        end
        IO_RD_SETUP: state <= IO_RD_SAMPLE;
        IO_RD_SAMPLE: begin
          o_sram_oe_n <= 1'b1;
          if (wr_en_q) begin
            // chip stays selected for the write half
            state       <= IO_WR_PULSE;
            o_sram_we_n <= 1'b0;
            data_oe     <= 1'b1;
          end else begin
            state       <= IO_RD_RESP;
            o_sram_ce_n <= 1'b1;
          end
        end
        IO_WR_PULSE: begin
          state       <= IO_WR_RECOVER;
          o_sram_we_n <= 1'b1;
        end
        IO_WR_RECOVER: begin
          state       <= IO_IDLE;
          o_sram_ce_n <= 1'b1;
          data_oe     <= 1'b0;
        end
        IO_RD_RESP: begin
          if (i_rd_ready) begin
            state <= IO_IDLE;
          end
        end
        default: state <= IO_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (o_cmd_ready && i_cmd_valid) begin
      o_sram_addr <= i_cmd_addr;
      wr_data_q   <= i_cmd_wr_data;
      strb_q      <= i_cmd_wr_strb;
      wr_en_q     <= i_cmd_wr_en;
    end
    if (state == IO_RD_SAMPLE) begin
      rd_data_q <= io_sram_data;
      wr_data_q <= merged;
    end
  end

endmodule

//--- tests/async_sram_model.sv
`timescale 1ns/1ps

module async_sram_model
  import sram_ctrl_pkg::*;
(
  input  logic [SRAM_ADDR_W-1:0] i_addr,
  inout  wire  [AXIL_DATA_W-1:0] io_data,
  input  logic                   i_we_n,
  input  logic                   i_oe_n,
  input  logic                   i_ce_n
);

  logic [AXIL_DATA_W-1:0] mem [SRAM_DEPTH];

  // Chip powers up all zero
  initial begin
    for (int i = 0; i < SRAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign io_data = (!i_ce_n && !i_oe_n) ? mem[i_addr] : {AXIL_DATA_W{1'bz}};

  // Write is latched at the end of the we_n pulse
  always @(posedge i_we_n) begin
    if (!i_ce_n) begin
      mem[i_addr] = io_data;
    end
  end

endmodule

//--- tests/axil_sram_checker.sv
`timescale 1ns/1ps

module axil_sram_checker
  import sram_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_rst,
  input  logic [AXIL_ADDR_W-1:0] i_awaddr,
  input  logic                   i_awvalid,
  input  logic                   i_awready,
  input  logic [AXIL_DATA_W-1:0] i_wdata,
  input  logic [AXIL_STRB_W-1:0] i_wstrb,
  input  logic                   i_wvalid,
  input  logic                   i_wready,
  input  logic [1:0]             i_bresp,
  input  logic                   i_bvalid,
  input  logic                   i_bready,
  input  logic [AXIL_ADDR_W-1:0] i_araddr,
  input  logic                   i_arvalid,
  input  logic                   i_arready,
  input  logic [AXIL_DATA_W-1:0] i_rdata,
  input  logic [1:0]             i_rresp,
  input  logic                   i_rvalid,
  input  logic                   i_rready,
  input  logic [SRAM_ADDR_W-1:0] i_sram_addr,
  input  logic                   i_we_n,
  input  logic                   i_oe_n,
  input  logic                   i_ce_n,
  output int                     o_err_count
);

  logic [AXIL_DATA_W-1:0] shadow [SRAM_DEPTH];
  logic [SRAM_ADDR_W-1:0] aw_word_q;
  logic [SRAM_ADDR_W-1:0] ar_word_q;
  logic [AXIL_DATA_W-1:0] w_data_q;
  logic [AXIL_STRB_W-1:0] w_strb_q;
  logic [1:0]             bresp_q;
  logic [1:0]             rresp_q;
  logic [AXIL_DATA_W-1:0] rdata_q;
  logic                   b_hold;
  logic                   r_hold;
  logic                   rst_q;
  int                     wr_pend;
  int                     rd_pend;

  initial begin
    for (int i = 0; i < SRAM_DEPTH; i++) begin
      shadow[i] = '0;
    end
    o_err_count = 0;
    wr_pend = 0;
    rd_pend = 0;
    b_hold = 1'b0;
    r_hold = 1'b0;
    rst_q = 1'b1;
  end

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
      o_err_count++;
    end
  endtask

  task automatic report_text(input string what);
    $display("Error at %0t: %s", $time, what);
    o_err_count++;
  endtask

  always @(posedge clk) begin
    // Quiet bus right after reset
    if (rst_q && !i_rst) begin
      report_value("o_awready", 0, {31'd0, i_awready});
      report_value("o_wready", 0, {31'd0, i_wready});
      report_value("o_arready", 0, {31'd0, i_arready});
      report_value("o_bvalid", 0, {31'd0, i_bvalid});
      report_value("o_rvalid", 0, {31'd0, i_rvalid});
      report_value("o_sram_we_n", 1, {31'd0, i_we_n});
      report_value("o_sram_oe_n", 1, {31'd0, i_oe_n});
      report_value("o_sram_ce_n", 1, {31'd0, i_ce_n});
    end
    rst_q = i_rst;

    if (!i_rst) begin
      // Held responses must not change while stalled
      if (b_hold) begin
        if (!i_bvalid) begin
          report_text("bvalid dropped before bready was given");
        end else begin
          report_value("o_bresp", {30'd0, bresp_q}, {30'd0, i_bresp});
        end
      end
      if (r_hold) begin
        if (!i_rvalid) begin
          report_text("rvalid dropped before rready was given");
        end else begin
          report_value("o_rdata", {16'd0, rdata_q}, {16'd0, i_rdata});
          report_value("o_rresp", {30'd0, rresp_q}, {30'd0, i_rresp});
        end
      end
      b_hold = i_bvalid && !i_bready;
      r_hold = i_rvalid && !i_rready;
      bresp_q = i_bresp;
      rresp_q = i_rresp;
      rdata_q = i_rdata;

      if (i_awvalid && i_awready) begin
        aw_word_q = i_awaddr[AXIL_ADDR_W-1:1];
        wr_pend++;
      end
      if (i_wvalid && i_wready) begin
        w_data_q = i_wdata;
        w_strb_q = i_wstrb;
      end
      if (i_arvalid && i_arready) begin
        ar_word_q = i_araddr[AXIL_ADDR_W-1:1];
        rd_pend++;
      end

      if (i_bvalid && i_bready) begin
        if (wr_pend == 0) begin
          report_text("write response without an outstanding write");
        end else begin
          wr_pend--;
          report_value("o_bresp", {30'd0, RESP_OKAY}, {30'd0, i_bresp});
          // Pins still carry the word of the write just issued
          report_value("o_sram_addr", {25'd0, aw_word_q}, {25'd0, i_sram_addr});
          // Only strobed bytes land in the word
          if (w_strb_q[0]) begin
            shadow[aw_word_q][7:0] = w_data_q[7:0];
          end
          if (w_strb_q[1]) begin
            shadow[aw_word_q][15:8] = w_data_q[15:8];
          end
        end
      end

      if (i_rvalid && i_rready) begin
        if (rd_pend == 0) begin
          report_text("read response without an outstanding read");
        end else begin
          rd_pend--;
          report_value("o_rresp", {30'd0, RESP_OKAY}, {30'd0, i_rresp});
          report_value("o_sram_addr", {25'd0, ar_word_q}, {25'd0, i_sram_addr});
          report_value("o_rdata", {16'd0, shadow[ar_word_q]}, {16'd0, i_rdata});
        end
      end
    end
  end

endmodule

//--- tests/axil_sram_props.sv
`timescale 1ns/1ps

module axil_sram_props
  import sram_ctrl_pkg::*;
(
  input logic                   clk,
  input logic                   i_rst,
  input logic                   o_bvalid,
  input logic                   i_bready,
  input logic [1:0]             o_bresp,
  input logic                   o_rvalid,
  input logic                   i_rready,
  input logic [AXIL_DATA_W-1:0] o_rdata,
  input logic [1:0]             o_rresp,
  input logic                   o_sram_we_n,
  input logic                   o_sram_oe_n
);

  b_stable: assert property (@(posedge clk) disable iff (i_rst)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp))
    else $error("write response changed while stalled");

  r_stable: assert property (@(posedge clk) disable iff (i_rst)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp))
    else $error("read response changed while stalled");

  // Chip must never see a read and write strobe together
  pins_excl: assert property (@(posedge clk) disable iff (i_rst)
    !(!o_sram_oe_n && !o_sram_we_n))
    else $error("oe_n and we_n low together");

endmodule

bind axil_sram_top axil_sram_props u_props (.*);

//--- tests/tb_axil_sram.sv
`timescale 1ns/1ps

module tb_axil_sram;

  localparam int TIMEOUT = 200;

  logic        clk;
  logic        i_rst;
  logic [7:0]  i_awaddr;
  logic        i_awvalid;
  logic [15:0] i_wdata;
  logic [1:0]  i_wstrb;
  logic        i_wvalid;
  logic        i_bready;
  logic [7:0]  i_araddr;
  logic        i_arvalid;
  logic        i_rready;
  logic        o_awready;
  logic        o_wready;
  logic        o_arready;
  logic [1:0]  o_bresp;
  logic        o_bvalid;
  logic [15:0] o_rdata;
  logic [1:0]  o_rresp;
  logic        o_rvalid;
  logic [6:0]  sram_addr;
  wire  [15:0] sram_data;
  logic        sram_we_n;
  logic        sram_oe_n;
  logic        sram_ce_n;
  logic        aw_fire;
  logic        w_fire;
  logic        ar_fire;
  logic        b_fire;
  logic        r_fire;
  int          chk_errs;
  int          timeouts;
  integer      seed;

  tb_clock u_clk (.o_clk(clk));

  axil_sram_top uut (
    .clk(clk), .i_rst(i_rst),
    .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
    .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
    .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
    .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
    .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
    .o_sram_addr(sram_addr), .io_sram_data(sram_data),
    .o_sram_we_n(sram_we_n), .o_sram_oe_n(sram_oe_n), .o_sram_ce_n(sram_ce_n)
  );

  async_sram_model u_sram (
    .i_addr(sram_addr), .io_data(sram_data),
    .i_we_n(sram_we_n), .i_oe_n(sram_oe_n), .i_ce_n(sram_ce_n)
  );

  axil_sram_checker u_chk (
    .clk(clk), .i_rst(i_rst),
    .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .i_awready(o_awready),
    .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .i_wready(o_wready),
    .i_bresp(o_bresp), .i_bvalid(o_bvalid), .i_bready(i_bready),
    .i_araddr(i_araddr), .i_arvalid(i_arvalid), .i_arready(o_arready),
    .i_rdata(o_rdata), .i_rresp(o_rresp), .i_rvalid(o_rvalid), .i_rready(i_rready),
    .i_sram_addr(sram_addr),
    .i_we_n(sram_we_n), .i_oe_n(sram_oe_n), .i_ce_n(sram_ce_n),
    .o_err_count(chk_errs)
  );

  // Handshakes seen at the rising edge, read back on the next falling edge
  always @(posedge clk) begin
    aw_fire <= i_awvalid && o_awready;
    w_fire  <= i_wvalid && o_wready;
    ar_fire <= i_arvalid && o_arready;
    b_fire  <= o_bvalid && i_bready;
    r_fire  <= o_rvalid && i_rready;
  end

  task automatic run_txn(input logic do_wr, input logic do_rd, input logic [7:0] waddr,
                         input logic [15:0] wdata, input logic [1:0] wstrb,
                         input logic [7:0] raddr);
    int   cnt;
    int   order;
    logic aw_got;
    logic w_got;
    logic ar_got;
    logic b_got;
    logic r_got;
    order  = $unsigned($random(seed)) % 3;
    aw_got = !do_wr;
    w_got  = !do_wr;
    b_got  = !do_wr;
    ar_got = !do_rd;
    r_got  = !do_rd;
    cnt    = 0;
    @(negedge clk);
    i_awaddr  = waddr;
    i_wdata   = wdata;
    i_wstrb   = wstrb;
    i_araddr  = raddr;
    // Order 1 sends aw first, order 2 sends w first
    i_awvalid = do_wr && (order != 2);
    i_wvalid  = do_wr && (order != 1);
    i_arvalid = do_rd;
    while (!(aw_got && w_got && ar_got && b_got && r_got) && cnt < TIMEOUT) begin
      i_bready = (($random(seed) & 3) != 0);
      i_rready = (($random(seed) & 3) != 0);
      @(negedge clk);
      cnt++;
      if (aw_fire) begin
        aw_got    = 1'b1;
        i_awvalid = 1'b0;
        if (!w_got) i_wvalid = 1'b1;
      end
      if (w_fire) begin
        w_got    = 1'b1;
        i_wvalid = 1'b0;
        if (!aw_got) i_awvalid = 1'b1;
      end
      if (ar_fire) begin
        ar_got    = 1'b1;
        i_arvalid = 1'b0;
      end
      if (b_fire) b_got = 1'b1;
      if (r_fire) r_got = 1'b1;
    end
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    i_arvalid = 1'b0;
    i_bready  = 1'b0;
    i_rready  = 1'b0;
    if (cnt >= TIMEOUT) begin
      $display("Timeout at %0t: transaction did not finish its handshakes", $time);
      timeouts++;
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] rnd2;
    logic [7:0]  waddr;
    logic [7:0]  raddr;
    logic [1:0]  op;
    seed      = 32'hcda7;
    timeouts  = 0;
    i_rst     = 1'b1;
    i_awaddr  = '0;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b0;
    i_araddr  = '0;
    i_arvalid = 1'b0;
    i_rready  = 1'b0;
    repeat (8) @(negedge clk);
    i_rst = 1'b0;
    repeat (4) @(negedge clk);

    run_txn(1'b1, 1'b0, 8'h10, 16'hbeef, 2'b11, 8'h00);
    run_txn(1'b0, 1'b1, 8'h00, 16'h0000, 2'b00, 8'h10);
    run_txn(1'b1, 1'b0, 8'h10, 16'h1234, 2'b01, 8'h00);
    run_txn(1'b1, 1'b0, 8'h11, 16'h5678, 2'b10, 8'h00);
    run_txn(1'b0, 1'b1, 8'h00, 16'h0000, 2'b00, 8'h10);
    run_txn(1'b1, 1'b0, 8'h10, 16'hffff, 2'b00, 8'h00);
    run_txn(1'b0, 1'b1, 8'h00, 16'h0000, 2'b00, 8'h10);
    run_txn(1'b1, 1'b1, 8'h20, 16'ha5a5, 2'b11, 8'h10);

    for (int i = 0; i < 300 && timeouts == 0; i++) begin
      rnd   = $random(seed);
      rnd2  = $random(seed);
      op    = rnd[1:0];
      waddr = {3'b001, rnd[6:3], rnd[7]};
      raddr = {3'b001, rnd[11:8], rnd[12]};
      // Same-cycle pairs go to different words
      if (op == 2'd2 && raddr[4:1] == waddr[4:1]) begin
        raddr[1] = ~raddr[1];
      end
      run_txn(op != 2'd1, op == 2'd1 || op == 2'd2, waddr, rnd2[15:0], rnd[14:13], raddr);
    end

    repeat (4) @(negedge clk);
    $display("Checker errors: %0d, timeouts: %0d", chk_errs, timeouts);
    if (chk_errs == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic o_clk
);

  // 40 ns period
  initial o_clk = 1'b0;
  always #20 o_clk = ~o_clk;

endmodule
